/* rtl/cabinet_consts.svh */
`ifndef CABINET_CONSTS_SVH
`define CABINET_CONSTS_SVH

// ==============================
// Keyboard scancodes
// ==============================
`define KEY_UP       8'h75
`define KEY_DOWN     8'h72
`define KEY_LEFT     8'h6B
`define KEY_RIGHT    8'h74
`define KEY_COIN     8'h76 // Esc
`define KEY_START1   8'h05 // F1
`define KEY_START2   8'h06 // F2
`define KEY_FIRE1    8'h29 // Space
`define KEY_FIRE2    8'h11 // Alt
`define KEY_FIRE3    8'h14 // Ctrl

// Bit positions in a player control word
`define CTL_COIN     6
`define CTL_START    5
`define CTL_FIRE     4
`define CTL_UP       3
`define CTL_DOWN     2
`define CTL_LEFT     1
`define CTL_RIGHT    0

// ==============================
// Audio widths
// ==============================
`define SND_W        8  // One sound channel
`define MIX_W        11 // Weighted sum of both channels
`define DAC_W        16 // DAC input and accumulator

`endif

/* rtl/cabinet_pkg.sv */
package cabinet_pkg;

	// ==============================
	// Keyboard side
	// ==============================

	// Event word from the SPI controller, bit 10 down to bit 0
	typedef struct packed {
		logic       toggle;   // Flips once per new event
		logic       pressed;  // 1 on make, 0 on break
		logic       extended; // E0 prefix seen
		logic [7:0] code;
	} key_event_t;

	// Held state of every mapped key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} kbd_keys_t;

	// ==============================
	// Joysticks and player words
	// ==============================

	// Right sits at bit 0, as the board reports it
	typedef struct packed {
		logic spare2;
		logic spare1;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// Core order coin, start, fire, up, down, left, right
	typedef struct packed {
		logic coin;
		logic start;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_ctl_t;

endpackage

/* rtl/key_event_decoder.sv */
`timescale 1ns/1ps

`include "cabinet_consts.svh"

module key_event_decoder
	import cabinet_pkg::*;
(
	input  logic       clk_24,
	input  logic       arst_n,
	input  key_event_t key_event,
	output kbd_keys_t  keys
);

	logic toggle_q; // Toggle seen at the previous edge
	logic new_event;

	// Any change of the toggle bit announces one event
	assign new_event = (key_event.toggle != toggle_q);

	// ==============================
	// Toggle tracking
	// ==============================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
		end else if (new_event) begin
			toggle_q <= key_event.toggle;
		end
	end

	// ==============================
	// Held key state
	// ==============================

	// Each key keeps its level until its own scancode arrives again
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			keys <= '0;
		end else if (new_event) begin
			case (key_event.code)
				`KEY_UP: begin
					keys.up <= key_event.pressed;
				end
				`KEY_DOWN: begin
					keys.down <= key_event.pressed;
				end
				`KEY_LEFT: begin
					keys.left <= key_event.pressed;
				end
				`KEY_RIGHT: begin
					keys.right <= key_event.pressed;
				end
				`KEY_COIN: begin
					keys.coin <= key_event.pressed;
				end
				`KEY_START1: begin
					keys.start1 <= key_event.pressed;
				end
				`KEY_START2: begin
					keys.start2 <= key_event.pressed;
				end
				`KEY_FIRE1: begin
					keys.fire1 <= key_event.pressed;
				end
				`KEY_FIRE2: begin
					keys.fire2 <= key_event.pressed;
				end
				`KEY_FIRE3: begin
					keys.fire3 <= key_event.pressed;
				end
				default: begin
					keys <= keys; // Unknown code leaves every key alone
				end
			endcase
		end
	end

endmodule

/* rtl/control_mapper.sv */
`timescale 1ns/1ps

module control_mapper
	import cabinet_pkg::*;
(
	input  logic        clk_24,
	input  logic        arst_n,
	input  kbd_keys_t   keys,
	input  joy_t        joy_a,
	input  joy_t        joy_b,
	input  logic        rotate,
	output player_ctl_t p1_ctl,
	output player_ctl_t p2_ctl
);

	// Merged keyboard and joystick directions
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	player_ctl_t p1_next;
	player_ctl_t p2_next;

	// ==============================
	// Merge all sources
	// ==============================
	assign m_up    = keys.up    | joy_a.up    | joy_b.up;
	assign m_down  = keys.down  | joy_a.down  | joy_b.down;
	assign m_left  = keys.left  | joy_a.left  | joy_b.left;
	assign m_right = keys.right | joy_a.right | joy_b.right;
	assign m_fire  = keys.fire1 | joy_a.fire1 | joy_b.fire1;

	// Shared fire and directions, per-player coin and start
	always_comb begin
		p1_next.coin  = keys.coin;
		p1_next.start = keys.start1;
		p1_next.fire  = m_fire;
		if (rotate) begin // Quarter turn for a vertical cabinet
			p1_next.up    = m_left;
			p1_next.down  = m_right;
			p1_next.left  = m_down;
			p1_next.right = m_up;
		end else begin
			p1_next.up    = m_up;
			p1_next.down  = m_down;
			p1_next.left  = m_left;
			p1_next.right = m_right;
		end

		p2_next       = p1_next;
		p2_next.coin  = 1'b0; // Single coin slot on player one
		p2_next.start = keys.start2;
	end

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			p1_ctl <= '0;
			p2_ctl <= '0;
		end else begin
			p1_ctl <= p1_next;
			p2_ctl <= p2_next;
		end
	end

endmodule

/* rtl/audio_dac.sv */
`timescale 1ns/1ps

`include "cabinet_consts.svh"

module audio_dac
	import cabinet_pkg::*;
(
	input  logic              clk_24,
	input  logic              arst_n,
	input  logic [`SND_W-1:0] snd_a,
	input  logic [`SND_W-1:0] snd_b,
	output logic              audio_out
);

	logic [`MIX_W-1:0] mix;
	logic [`DAC_W-1:0] dac_in;
	logic [`DAC_W-1:0] acc;
	logic [`DAC_W-1:0] acc_sum;
	logic              acc_carry;

	// ==============================
	// Channel mixer
	// ==============================

	// Second channel carries four times the weight of the first
	assign mix = (`MIX_W'(snd_b) << 2) + `MIX_W'(snd_a);

	// Left aligned into the DAC range
	assign dac_in = {mix, {(`DAC_W - `MIX_W){1'b0}}};

	// ==============================
	// First-order sigma-delta
	// ==============================

	// The carry out of the accumulator is the 1-bit stream
	assign {acc_carry, acc_sum} = {1'b0, acc} + {1'b0, dac_in};

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= acc_sum;   // Keeps the residue for the next cycle
			audio_out <= acc_carry; // One pulse per overflow
		end
	end

	// Ones density over N cycles is dac_in * N / 2^DAC_W

endmodule

/* rtl/cabinet_io.sv */
`timescale 1ns/1ps

module cabinet_io
	import cabinet_pkg::*;
(
	input  logic        clk_24,
	input  logic        arst_n,
	input  key_event_t  key_event,
	input  joy_t        joy_a,
	input  joy_t        joy_b,
	input  logic        rotate,
	input  logic [7:0]  snd_a,
	input  logic [7:0]  snd_b,
	output player_ctl_t p1_ctl,
	output player_ctl_t p2_ctl,
	output logic        audio_out
);

	kbd_keys_t kbd_keys; // Held keys from the decoder

	// ==============================
	// Control path
	// ==============================
	key_event_decoder u_key_event_decoder (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.key_event (key_event),
		.keys      (kbd_keys)
	);

	control_mapper u_control_mapper (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.keys   (kbd_keys),
		.joy_a  (joy_a),
		.joy_b  (joy_b),
		.rotate (rotate),
		.p1_ctl (p1_ctl),
		.p2_ctl (p2_ctl)
	);

	// ==============================
	// Sound path
	// ==============================
	audio_dac u_audio_dac (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.snd_a     (snd_a),
		.snd_b     (snd_b),
		.audio_out (audio_out)
	);

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	input  logic rst_req, // Extra reset from the testbench
	output logic clk_24,
	output logic arst_n
);

	logic por_n; // Power-on reset, released after 8 cycles
	int   cnt;

	initial begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	initial begin
		por_n = 1'b0;
		for (cnt = 0; cnt < 8; cnt++) begin
			@(posedge clk_24);
		end
		por_n <= 1'b1;
	end

	assign arst_n = por_n & ~rst_req;

endmodule

/* sim/cabinet_io_chk.sv */
`timescale 1ns/1ps

module cabinet_io_chk
	import cabinet_pkg::*;
(
	input logic        clk_24,
	input logic        arst_n,
	input player_ctl_t p1_ctl,
	input player_ctl_t p2_ctl,
	input logic        audio_out
);

	// ==============================
	// Reset values
	// ==============================

	// First edge after release still shows what reset left behind
	a_clear_out_of_reset: assert property (@(posedge clk_24)
		$rose(arst_n) |-> (p1_ctl == '0) && (p2_ctl == '0) && !audio_out)
		else $error("outputs not zero when reset was released");

	// ==============================
	// Player words
	// ==============================

	// Only player one has a coin slot
	a_p2_no_coin: assert property (@(posedge clk_24) disable iff (!arst_n)
		p2_ctl.coin == 1'b0)
		else $error("player two coin bit set");

endmodule

/* sim/cabinet_io_tb.sv */
`timescale 1ns/1ps

`include "cabinet_consts.svh"

module cabinet_io_tb
	import cabinet_pkg::*;
();

	// One table row, stimulus and expected player words
	typedef struct packed {
		logic [7:0]  code;
		logic        pressed;
		logic        toggle; // Flip the event toggle
		joy_t        joy_a;
		joy_t        joy_b;
		logic        rotate;
		player_ctl_t exp_p1;
		player_ctl_t exp_p2;
	} row_t;

	logic        clk_24;
	logic        arst_n;
	logic        rst_req;
	key_event_t  key_event;
	joy_t        joy_a;
	joy_t        joy_b;
	logic        rotate;
	logic [7:0]  snd_a;
	logic [7:0]  snd_b;
	player_ctl_t p1_ctl;
	player_ctl_t p2_ctl;
	logic        audio_out;

	row_t      rows[$];
	string     names[$];
	kbd_keys_t model_keys; // Held keys as the testbench tracks them
	logic      tog_state;
	integer    seed;
	int        test_errors;
	int        total_errors;
	int        pass_count;
	int        fail_count;

	// Same order as the fields of kbd_keys_t, up first
	logic [7:0] key_codes [10] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_COIN,
		`KEY_START1, `KEY_START2, `KEY_FIRE1, `KEY_FIRE2, `KEY_FIRE3};
	string key_names [10] = '{"up", "down", "left", "right", "coin",
		"start1", "start2", "fire1", "fire2", "fire3"};

	clk_gen u_clk_gen (.rst_req(rst_req), .clk_24(clk_24), .arst_n(arst_n));

	cabinet_io uut (
		.clk_24(clk_24), .arst_n(arst_n), .key_event(key_event),
		.joy_a(joy_a), .joy_b(joy_b), .rotate(rotate), .snd_a(snd_a), .snd_b(snd_b),
		.p1_ctl(p1_ctl), .p2_ctl(p2_ctl), .audio_out(audio_out)
	);

	bind cabinet_io cabinet_io_chk u_chk (
		.clk_24(clk_24), .arst_n(arst_n), .p1_ctl(p1_ctl), .p2_ctl(p2_ctl),
		.audio_out(audio_out)
	);

	// ==============================
	// Reference model
	// ==============================
	function automatic player_ctl_t expect_ctl(input kbd_keys_t k, input joy_t ja,
		input joy_t jb, input logic rot, input logic second);
		logic [3:0]  dir; // Up, down, left, right
		player_ctl_t p;
		dir = {k.up | ja.up | jb.up, k.down | ja.down | jb.down,
			k.left | ja.left | jb.left, k.right | ja.right | jb.right};
		p = '0;
		p.fire = k.fire1 | ja.fire1 | jb.fire1;
		if (rot) begin // Up from left, down from right, left from down, right from up
			{p.up, p.down, p.left, p.right} = {dir[1], dir[0], dir[2], dir[3]};
		end else begin
			{p.up, p.down, p.left, p.right} = dir;
		end
		if (second) begin
			p.start = k.start2;
		end else begin
			p.coin  = k.coin;
			p.start = k.start1;
		end
		return p;
	endfunction

	task automatic add_row(input string name, input logic [7:0] code, input logic pressed,
		input logic toggle, input joy_t ja, input joy_t jb, input logic rot);
		row_t r;
		int   k;
		if (toggle) begin
			for (k = 0; k < 10; k++) begin
				if (code == key_codes[k]) begin
					model_keys[9 - k] = pressed;
				end
			end
		end
		r = {code, pressed, toggle, ja, jb, rot, 7'h00, 7'h00};
		r.exp_p1 = expect_ctl(model_keys, ja, jb, rot, 1'b0);
		r.exp_p2 = expect_ctl(model_keys, ja, jb, rot, 1'b1);
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		logic [7:0]  one_hot;
		int          k;
		for (k = 0; k < 10; k++) begin
			add_row({"press ", key_names[k]}, key_codes[k], 1'b1, 1'b1, '0, '0, 1'b0);
			add_row({"release ", key_names[k]}, key_codes[k], 1'b0, 1'b1, '0, '0, 1'b0);
		end
		// Words that carry no new event
		add_row("hold up", `KEY_UP, 1'b1, 1'b1, '0, '0, 1'b0);
		add_row("same word again", `KEY_UP, 1'b1, 1'b0, '0, '0, 1'b0);
		add_row("break without toggle", `KEY_UP, 1'b0, 1'b0, '0, '0, 1'b0);
		add_row("unknown scancode", 8'h1C, 1'b1, 1'b1, '0, '0, 1'b0);
		add_row("release up", `KEY_UP, 1'b0, 1'b1, '0, '0, 1'b0);
		for (k = 0; k < 8; k++) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			add_row($sformatf("random joysticks %0d", k), 8'h00, 1'b0, 1'b0,
				rnd_a[7:0], rnd_b[7:0], 1'b0);
		end
		// Quarter turn, keys first
		for (k = 0; k < 4; k++) begin
			add_row({"rotated press ", key_names[k]}, key_codes[k], 1'b1, 1'b1, '0, '0, 1'b1);
			add_row({"rotated release ", key_names[k]}, key_codes[k], 1'b0, 1'b1, '0, '0, 1'b1);
		end
		for (k = 0; k < 4; k++) begin
			one_hot = 8'h01 << k;
			add_row($sformatf("rotated joy_a bit %0d", k), 8'h00, 1'b0, 1'b0, one_hot, '0, 1'b1);
			add_row($sformatf("rotated joy_b bit %0d", k), 8'h00, 1'b0, 1'b0, '0, one_hot, 1'b1);
		end
		add_row("rotated up and right", 8'h00, 1'b0, 1'b0, 8'h08, 8'h01, 1'b1);
		add_row("rotate back to straight", 8'h00, 1'b0, 1'b0, 8'h08, 8'h01, 1'b0);
		add_row("joysticks idle", 8'h00, 1'b0, 1'b0, '0, '0, 1'b0);
	endtask

	// ==============================
	// Checks and reporting
	// ==============================
	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("ok      %s", name);
		end else begin
			fail_count++;
			$display("failed  %s (%0d errors)", name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	task automatic check_zero_outputs();
		if (p1_ctl !== 7'h00) begin
			$display("Fail p1_ctl: expected %h, got %h", 7'h00, p1_ctl);
			test_errors++;
		end
		if (p2_ctl !== 7'h00) begin
			$display("Fail p2_ctl: expected %h, got %h", 7'h00, p2_ctl);
			test_errors++;
		end
		if (audio_out !== 1'b0) begin
			$display("Fail audio_out: expected %h, got %h", 1'b0, audio_out);
			test_errors++;
		end
	endtask

	task automatic wait_reset_release();
		int cnt;
		cnt = 0;
		do begin
			@(posedge clk_24);
			cnt++;
		end while (arst_n !== 1'b1 && cnt < 50);
		if (arst_n !== 1'b1) begin
			$display("Reset was still asserted after %0d cycles", cnt);
			test_errors++;
		end
	endtask

	task automatic run_row(input int i);
		int n;
		int lat;
		@(posedge clk_24);
		if (rows[i].toggle) begin
			tog_state = ~tog_state;
		end
		key_event <= {tog_state, rows[i].pressed, 1'b0, rows[i].code};
		joy_a     <= rows[i].joy_a;
		joy_b     <= rows[i].joy_b;
		rotate    <= rows[i].rotate;
		// Key words pass the decoder register too
		lat = (rows[i].toggle || rows[i].code != 8'h00) ? 2 : 1;
		for (n = 0; n < lat; n++) begin
			@(posedge clk_24);
		end
		@(negedge clk_24);
		if (p1_ctl !== rows[i].exp_p1) begin
			$display("Fail p1_ctl: expected %h, got %h", rows[i].exp_p1, p1_ctl);
			test_errors++;
		end
		if (p2_ctl !== rows[i].exp_p2) begin
			$display("Fail p2_ctl: expected %h, got %h", rows[i].exp_p2, p2_ctl);
			test_errors++;
		end
		finish_test(names[i]);
	endtask

	task automatic check_audio(input logic [7:0] a, input logic [7:0] b);
		int n;
		int ones;
		int expected;
		@(posedge clk_24);
		snd_a <= a;
		snd_b <= b;
		@(posedge clk_24);
		ones = 0;
		for (n = 0; n < 4096; n++) begin
			@(negedge clk_24);
			if (audio_out) begin
				ones++;
			end
		end
		expected = ((4 * int'(b) + int'(a)) * 32 * 4096) / 65536; // Mix times 32 over 2^16
		if (ones < expected - 1 || ones > expected + 1) begin
			$display("Fail audio_out ones: expected %h, got %h", expected, ones);
			test_errors++;
		end
		finish_test($sformatf("audio density a=%h b=%h", a, b));
	endtask

	task automatic check_reset_midrun();
		add_row("coin before reset", `KEY_COIN, 1'b1, 1'b1, '0, '0, 1'b0);
		run_row(rows.size() - 1);
		add_row("left before reset", `KEY_LEFT, 1'b1, 1'b1, '0, '0, 1'b0);
		run_row(rows.size() - 1);
		@(posedge clk_24);
		snd_a <= 8'hA5;
		snd_b <= 8'h5A;
		@(posedge clk_24);
		rst_req   <= 1'b1; // Keys held and DAC running
		key_event <= '0;
		snd_a     <= '0;
		snd_b     <= '0;
		tog_state = 1'b0;
		model_keys = '0;
		@(negedge clk_24);
		check_zero_outputs();
		@(posedge clk_24);
		rst_req <= 1'b0;
		wait_reset_release();
		finish_test("reset in mid-run");
		add_row("held keys forgotten", 8'h00, 1'b0, 1'b0, '0, '0, 1'b0);
		run_row(rows.size() - 1);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		logic [31:0] rnd;
		int          i;
		rst_req      = 1'b0;
		key_event    = '0;
		joy_a        = '0;
		joy_b        = '0;
		rotate       = 1'b0;
		snd_a        = '0;
		snd_b        = '0;
		seed         = 32'he450d180;
		model_keys   = '0;
		tog_state    = 1'b0;
		test_errors  = 0;
		total_errors = 0;
		pass_count   = 0;
		fail_count   = 0;
		build_table();

		wait_reset_release();
		@(negedge clk_24);
		check_zero_outputs();
		finish_test("power-on reset");

		for (i = 0; i < rows.size(); i++) begin
			run_row(i);
		end

		check_audio(8'h00, 8'h00);
		check_audio(8'hFF, 8'h00);
		check_audio(8'h00, 8'hFF);
		check_audio(8'hFF, 8'hFF);
		check_audio(8'h37, 8'h5C);
		rnd = $random(seed);
		check_audio(rnd[7:0], rnd[15:8]);

		check_reset_midrun();

		$display("Summary: %0d tests passed, %0d failed, %0d errors",
			pass_count, fail_count, total_errors);
		if (fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/cabinet_pkg.sv
rtl/key_event_decoder.sv
rtl/control_mapper.sv
rtl/audio_dac.sv
rtl/cabinet_io.sv
sim/clk_gen.sv
sim/cabinet_io_chk.sv
sim/cabinet_io_tb.sv

/* Makefile */
# Verilator build and run of the cabinet I/O testbench

VERILATOR ?= verilator
TOP       ?= cabinet_io_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= PASS: all tests

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  build  compile only"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
